// ==== Makefile ====
# Verilator lint, build and run for the sprite controller testbench

VERILATOR  ?= verilator
TOP        ?= tb_sprite_ctrl
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
SIM_ARGS   ?= +verilator+error+limit+1000
FAIL_MSG   ?= === FAIL ===
PASS_MSG   ?= === PASS ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/sprite_cases.txt ====
// Columns: op addr data expected, all hex; op 0 ends the list
// Ops: 1 reg wr, 2 reg rd, 3 RAM wr, 4 RAM rd, 5 wait frames, 6 attr (data = sprite),
// 7 ROM (data = bank), 8 raster frame, 9 rst, A line flags (addr = mask), B vblank flags, C flags
8 000 00 108
5 000 08 0
9 000 00 8
3 418 85 85   // sprite 3, priority 5
3 450 8A 8A
3 4A0 85 85   // sprite 20 takes priority 5
3 4F0 C0 C0
3 540 40 40   // sprite 40 inactive, priority 40
3 7F8 FF FF
3 451 3C 3C
4 451 00 3C
4 4A0 00 85
1 000 10 0
B 000 00 7
2 000 00 1
A 1FF 180 7
2 000 00 0
6 005 14 0
6 00A 0A 0
6 040 1E 0
6 07F 7F 0
1 002 5A 0
1 003 B7 0
1 004 02 0
1 000 30 0
7 4A8 AD 35A2A
1 000 10 0
7 4A8 AD 0
A 1FF 180 7
1 000 11 0
C 000 00 7
B 000 00 6
1 000 10 0
C 000 00 7
A 001 001 7
1 000 12 0
C 000 00 7
A 001 000 5
1 000 10 0
C 000 00 7
A 01F 001 7
1 000 14 0
A 01F 01F 7
A 01F 000 3
1 000 10 0
C 000 00 7

// ==== bench/sprite_ctrl_assert.sv ====
// Bus strobe and slot checks, bound into every sprite_bus_arbiter
// Checked on clk_12M rising edges outside reset only
`timescale 1ns/1ps

module sprite_ctrl_assert (
	input logic clk_12M,
	input logic RES_SYNC,
	input logic pix_en,
	input logic cpu_grant,
	input logic copy_grant,
	input logic owr_n,
	input logic ooe_n
);

	int unsigned fail_count = 0;

	// Write strobe only in a CPU slot, never together with output enable
	strobe_excl: assert property (@(posedge clk_12M) disable iff (!RES_SYNC)
		!owr_n |-> (ooe_n && cpu_grant))
	else begin
		fail_count++;
		$error("write strobe outside a CPU slot or with ooe_n low at %0d ns", $time);
	end

	// Copy engine owns the pixel-enable slots only
	copy_slot: assert property (@(posedge clk_12M) disable iff (!RES_SYNC)
		copy_grant |-> pix_en)
	else begin
		fail_count++;
		$error("copy grant outside a pixel-enable slot at %0d ns", $time);
	end

endmodule

bind sprite_bus_arbiter sprite_ctrl_assert u_assert (
	.clk_12M   (clk_12M),
	.RES_SYNC  (RES_SYNC),
	.pix_en    (pix_en),
	.cpu_grant (cpu_grant),
	.copy_grant(copy_grant),
	.owr_n     (owr_n),
	.ooe_n     (ooe_n)
);

// ==== bench/tb_sprite_ctrl.sv ====
// Testbench for sprite_ctrl_top, driven from bench/sprite_cases.txt
// Run from the project root; flip stays off so raster.v is the raw line count
`timescale 1ns/1ps

module tb_sprite_ctrl;

	import sprite_pkg::*;

	localparam int MAX_CASES = 64;
	localparam int CPU_HOLD = 4;
	localparam longint FRAME_CLOCKS = 264 * 768;
	localparam int MARGIN_FRAMES = 4;
	localparam logic [31:0] LFSR_SEED = 32'h2da74717;

	logic clk_12M = 1'b0;
	logic RES_SYNC;
	cpu_bus_t cpu;
	byte_t db_out;
	spr_addr_t oa;
	byte_t od_out;
	byte_t od_in;
	logic owr_n;
	logic ooe_n;
	rom_addr_t rom_addr;
	rom_bank_t rom_bank;
	logic irq_n;
	logic firq_n;
	logic nmi_n;
	logic rst;
	raster_t raster;
	prio_t attr_index;
	attr_t attr;

	byte_t spr_mem [1024];
	logic [31:0] case_mem [4*MAX_CASES];
	logic case_bad;
	int passed = 0;
	int failed = 0;
	int vbl_seen = 0;
	int rst_at = 0;
	longint limit_cycles = 0;

	always #50 clk_12M = ~clk_12M;

	sprite_ctrl_top dut0 (
		.clk_12M   (clk_12M),
		.RES_SYNC  (RES_SYNC),
		.cpu       (cpu),
		.db_out    (db_out),
		.oa        (oa),
		.od_out    (od_out),
		.owr_n     (owr_n),
		.ooe_n     (ooe_n),
		.od_in     (od_in),
		.rom_addr  (rom_addr),
		.rom_bank  (rom_bank),
		.irq_n     (irq_n),
		.firq_n    (firq_n),
		.nmi_n     (nmi_n),
		.rst       (rst),
		.raster    (raster),
		.attr_index(attr_index),
		.attr      (attr)
	);

	// Sprite RAM model, asynchronous read
	assign od_in = spr_mem[oa];

	always @(posedge clk_12M) begin
		if (!owr_n) begin
			spr_mem[oa] <= od_out;
		end
	end

	// Vblank starts counted from reset, and the count at which rst rose
	always @(negedge clk_12M) begin
		if (RES_SYNC) begin
			if (raster.vblank_start) begin
				vbl_seen <= vbl_seen + 1;
			end
			if (rst && rst_at == 0) begin
				rst_at <= vbl_seen;
			end
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic string op_name(input logic [3:0] op);
		case (op)
			4'h1: return "register write";
			4'h2: return "register read";
			4'h3: return "sprite RAM write";
			4'h4: return "sprite RAM read";
			4'h5: return "wait frames";
			4'h6: return "attribute check";
			4'h7: return "ROM check";
			4'h8: return "raster frame";
			4'h9: return "reset delay";
			4'hA: return "line interrupt";
			4'hB: return "vblank interrupt";
			default: return "interrupt flags";
		endcase
	endfunction

	// Filler bytes, one LFSR step per bit; heads are left inactive
	task automatic fill_sprite_ram();
		logic [31:0] state;
		byte_t b;
		state = LFSR_SEED;
		for (int a = 0; a < 1024; a++) begin
			b = '0;
			for (int k = 0; k < 8; k++) begin
				state = lfsr_next(state);
				b = {b[6:0], state[0]};
			end
			if (a[2:0] == 3'd0) begin
				b[7] = 1'b0;
			end
			spr_mem[a] <= b;
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
			case_bad = 1'b1;
		end
	endtask

	task automatic report_case(input int idx, input string what);
		if (case_bad) begin
			failed++;
		end else begin
			passed++;
		end
		$display("case %0d %s: %s", idx, what, case_bad ? "failed" : "ok");
	endtask

	// One strobe held CPU_HOLD clocks; starts and ends on a falling edge
	task automatic cpu_cycle(input cpu_addr_t ab, input byte_t din, input logic write,
		output byte_t rdata);
		cpu.ab  = ab;
		cpu.din = din;
		cpu.cs  = 1'b1;
		cpu.wr  = write;
		cpu.rd  = !write;
		repeat (CPU_HOLD) @(negedge clk_12M);
		rdata  = db_out;
		cpu.cs = 1'b0;
		cpu.rd = 1'b0;
		cpu.wr = 1'b0;
		@(negedge clk_12M);
	endtask

	task automatic wait_line(input pix_t mask, input pix_t value);
		do @(negedge clk_12M);
		while (!(raster.line_start && ((raster.v & mask) == value)));
	endtask

	task automatic wait_frames(input int count);
		repeat (count) begin
			do @(negedge clk_12M);
			while (!raster.frame_end);
		end
	endtask

	// Frame from one frame_end to the next, ranges checked on every clock
	task automatic check_raster_frame(input int exp_lines);
		int lines;
		logic done;
		logic ok;
		logic vb_exp;
		logic vbs_exp;
		logic pix_prev;
		lines = 0;
		done = 1'b0;
		wait_frames(1);
		pix_prev = raster.pix_en;
		while (!done) begin
			@(negedge clk_12M);
			// Blanking covers lines 1F0 to 1FF and F8 to 10F
			vb_exp = (raster.v >= 9'h1F0) || ((raster.v >= 9'h0F8) && (raster.v <= 9'h10F));
			vbs_exp = raster.line_start && (raster.v == 9'h1F0);
			ok = (raster.h >= H_FIRST) && (raster.h <= H_LAST) &&
				(raster.v >= V_FIRST) && (raster.v <= V_LAST) && (raster.vblank == vb_exp) &&
				(raster.vblank_start == vbs_exp) && (raster.pix_en != pix_prev);
			assert (ok) else begin
				$display("Raster outside its limits at %0d ns: h=%h v=%h vblank=%b",
					$time, raster.h, raster.v, raster.vblank);
				$display("  vblank_start=%b pix_en=%b, previous pix_en=%b",
					raster.vblank_start, raster.pix_en, pix_prev);
				case_bad = 1'b1;
			end
			if (raster.line_start) begin
				lines++;
			end
			pix_prev = raster.pix_en;
			done = raster.frame_end || !ok;
		end
		check_value("line_start count", 64'(lines), 64'(exp_lines));
	endtask

	task automatic run_case(input logic [3:0] op, input logic [31:0] addr,
		input logic [31:0] data, input logic [31:0] exp);
		byte_t rdata;
		attr_t exp_attr;
		int base;
		case (op)
			4'h1: cpu_cycle(addr[10:0], data[7:0], 1'b1, rdata);
			4'h2, 4'h4: begin
				cpu_cycle(addr[10:0], 8'h00, 1'b0, rdata);
				check_value("db_out", 64'(rdata), 64'(exp[7:0]));
			end
			4'h3: begin
				cpu_cycle(addr[10:0], data[7:0], 1'b1, rdata);
				check_value("sprite RAM byte", 64'(spr_mem[addr[9:0]]), 64'(exp[7:0]));
			end
			4'h5: wait_frames(int'(data));
			4'h6: begin
				attr_index = addr[6:0];
				@(negedge clk_12M);
				// Bytes 1 to 7 of the expected sprite, byte 1 lowest
				base = int'(data[6:0]) * SPR_BYTES;
				for (int k = 1; k < SPR_BYTES; k++) begin
					exp_attr[(k-1)*8 +: 8] = spr_mem[base + k];
				end
				check_value("attr", 64'(attr), 64'(exp_attr));
			end
			4'h7: begin
				cpu.ab = addr[10:0];
				cpu.cs = 1'b1;
				@(negedge clk_12M);
				check_value("rom_addr", 64'(rom_addr), 64'(exp[17:0]));
				check_value("rom_bank", 64'(rom_bank), 64'(data[7:0]));
				cpu = '0;
			end
			4'h8: check_raster_frame(int'(exp));
			4'h9: begin
				check_value("vblank starts before rst", 64'(rst_at), 64'(exp));
				check_value("rst", 64'(rst), 64'h1);
			end
			4'hA, 4'hB, 4'hC: begin
				if (op == 4'hA) begin
					wait_line(addr[8:0], data[8:0]);
				end else if (op == 4'hB) begin
					do @(negedge clk_12M);
					while (!raster.vblank_start);
				end
				@(negedge clk_12M);
				check_value("{nmi_n,firq_n,irq_n}", 64'({nmi_n, firq_n, irq_n}), 64'(exp[2:0]));
			end
			default: begin
				$display("Unknown operation %h in the case file", op);
				case_bad = 1'b1;
			end
		endcase
	endtask

	initial begin : watchdog
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk_12M);
		$display("Run did not finish within %0d clock cycles", limit_cycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : main
		int n_cases;
		int frames;
		int base;
		int unsigned bus_fails;
		cpu = '0;
		attr_index = '0;
		RES_SYNC = 1'b0;
		for (int i = 0; i < 4 * MAX_CASES; i++) begin
			case_mem[i] = '0;
		end
		$readmemh("bench/sprite_cases.txt", case_mem);
		fill_sprite_ram();
		n_cases = 0;
		frames = 0;
		while (n_cases < MAX_CASES && case_mem[4*n_cases] != 0) begin
			if (case_mem[4*n_cases] == 32'h5) begin
				frames += int'(case_mem[4*n_cases+2]);
			end
			n_cases++;
		end
		limit_cycles = longint'(n_cases + frames + MARGIN_FRAMES) * FRAME_CLOCKS;

		repeat (2) @(negedge clk_12M);
		RES_SYNC = 1'b1;
		@(negedge clk_12M);
		case_bad = 1'b0;
		check_value("{nmi_n,firq_n,irq_n}", 64'({nmi_n, firq_n, irq_n}), 64'h7);
		check_value("rst", 64'(rst), 64'h0);
		check_value("owr_n", 64'(owr_n), 64'h1);
		check_value("ooe_n", 64'(ooe_n), 64'h1);
		report_case(0, "reset state");

		for (int c = 0; c < n_cases; c++) begin
			base = 4 * c;
			case_bad = 1'b0;
			run_case(case_mem[base][3:0], case_mem[base+1], case_mem[base+2], case_mem[base+3]);
			report_case(c + 1, op_name(case_mem[base][3:0]));
		end

		bus_fails = dut0.u_arb.u_assert.fail_count;
		if (bus_fails != 0) begin
			$display("Bus assertions fired %0d times", bus_fails);
		end
		$display("%0d cases run, %0d passed, %0d failed, %0d bus assertion failures",
			passed + failed, passed, failed, bus_fails);
		if (failed == 0 && bus_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== hdl/cpu_regs.sv ====
// CPU side: register file, interrupt flags, reset delay and sprite RAM port
// CPU strobes are levels held at least four clocks; one RAM access per strobe
`timescale 1ns/1ps

module cpu_regs (
	input  logic                  clk_12M,
	input  logic                  RES_SYNC,
	input  sprite_pkg::cpu_bus_t  cpu,
	input  sprite_pkg::raster_t   raster,
	input  logic                  copy_busy,
	input  logic                  spr_grant,
	input  sprite_pkg::byte_t     od_in,
	output sprite_pkg::byte_t     db_out,
	output sprite_pkg::ctrl_t     ctrl,
	output sprite_pkg::spr_req_t  spr_req,
	output logic                  spr_want,
	output sprite_pkg::rom_addr_t rom_addr,
	output sprite_pkg::rom_bank_t rom_bank,
	output logic                  irq_n,
	output logic                  firq_n,
	output logic                  nmi_n,
	output logic                  rst
);

	import sprite_pkg::*;

	ctrl_t ctrl_q;
	byte_t bank_lo;
	byte_t bank_hi;
	logic [1:0] bank_x;
	logic wr_q;
	logic wr_rise;
	logic reg_sel;
	logic spr_sel;
	logic spr_done;
	byte_t rd_lat;
	logic [2:0] int_evt;
	logic [2:0] int_en;
	logic [2:0] int_q;
	logic [RST_FRAMES-1:0] rst_sr;

	// Registers sit in the first eight bytes of the lower half
	assign reg_sel = cpu.cs && !cpu.ab[10] && (cpu.ab[9:3] == 7'd0);
	// Upper half is sprite RAM unless the ROM window is open
	assign spr_sel = cpu.cs && cpu.ab[10] && !ctrl_q.rom_read;
	assign wr_rise = cpu.wr && !wr_q;

	always_ff @(posedge clk_12M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			wr_q    <= 1'b0;
			ctrl_q  <= '0;
			bank_lo <= '0;
			bank_hi <= '0;
			bank_x  <= '0;
		end else begin
			wr_q <= cpu.wr;
			if (wr_rise && reg_sel) begin
				case (cpu.ab[2:0])
					REG_CTRL: begin
						ctrl_q.irq_en   <= cpu.din[0];
						ctrl_q.firq_en  <= cpu.din[1];
						ctrl_q.nmi_en   <= cpu.din[2];
						ctrl_q.flip     <= cpu.din[3];
						ctrl_q.copy_en  <= cpu.din[4];
						ctrl_q.rom_read <= cpu.din[5];
					end
					REG_BANK_LO: bank_lo <= cpu.din;
					REG_BANK_HI: bank_hi <= cpu.din;
					REG_BANK_X:  bank_x  <= cpu.din[1:0];
					default: ;
				endcase
			end
		end
	end

	assign ctrl = ctrl_q;

	// Flags set on their raster event, cleared while disabled
	assign int_evt = {raster.line_start && (raster.v[4:0] == 5'd0),
		raster.line_start && !raster.v[0],
		raster.vblank_start};
	assign int_en = {ctrl_q.nmi_en, ctrl_q.firq_en, ctrl_q.irq_en};

	always_ff @(posedge clk_12M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			int_q    <= '0;
			rst_sr   <= '0;
			spr_done <= 1'b0;
		end else begin
			int_q <= (int_q | int_evt) & int_en;
			if (raster.vblank_start) begin
				rst_sr <= {rst_sr[RST_FRAMES-2:0], 1'b1};
			end
			// Re-armed once the strobe drops
			if (!(cpu.rd || cpu.wr)) begin
				spr_done <= 1'b0;
			end else if (spr_grant) begin
				spr_done <= 1'b1;
			end
		end
	end

	assign {nmi_n, firq_n, irq_n} = ~int_q;
	assign rst = rst_sr[RST_FRAMES-1];

	assign spr_want = spr_sel && (cpu.rd || cpu.wr) && !spr_done;
	assign spr_req.addr  = cpu.ab[9:0];
	assign spr_req.wdata = cpu.din;
	assign spr_req.we    = cpu.wr;

	// Read byte is only valid during the grant cycle
	always_ff @(posedge clk_12M) begin
		if (spr_grant && cpu.rd) begin
			rd_lat <= od_in;
		end
	end

	assign db_out = (reg_sel && cpu.rd && (cpu.ab[2:0] == REG_CTRL)) ?
		{7'd0, copy_busy} : rd_lat;

	assign rom_addr = ctrl_q.rom_read ? {bank_hi[1:0], bank_lo, cpu.ab[9:2]} : '0;
	assign rom_bank = {bank_x, bank_hi[7:2]};

endmodule

// ==== hdl/raster_timer.sv ====
// Pixel and line counters, one pixel every second clk_12M cycle
// With flip set the low eight bits of v are inverted; blanking uses the raw count
`timescale 1ns/1ps

module raster_timer (
	input  logic                clk_12M,
	input  logic                RES_SYNC,
	input  logic                flip,
	output sprite_pkg::raster_t raster
);

	import sprite_pkg::*;

	logic pix_en_q;
	pix_t h_cnt;
	pix_t v_cnt;
	pix_t v_next;
	logic line_end;
	logic vblank;
	logic line_start_q;
	logic vblank_start_q;
	logic frame_end_q;

	// Last pixel of the line, only on a pixel-enable cycle
	assign line_end = pix_en_q && (h_cnt == H_LAST);
	assign v_next = (v_cnt == V_LAST) ? V_FIRST : v_cnt + 9'd1;

	// Window wraps through the end of the frame
	assign vblank = (v_cnt >= VBL_ON) || (v_cnt < VBL_OFF);

	always_ff @(posedge clk_12M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			pix_en_q       <= 1'b0;
			h_cnt          <= H_FIRST;
			v_cnt          <= V_FIRST;
			line_start_q   <= 1'b0;
			vblank_start_q <= 1'b0;
			frame_end_q    <= 1'b0;
		end else begin
			pix_en_q <= ~pix_en_q;

			// Pulses mark the first clock of the new line
			line_start_q   <= line_end;
			vblank_start_q <= line_end && (v_next == VBL_ON);
			frame_end_q    <= line_end && (v_cnt == V_LAST);

			if (pix_en_q) begin
				h_cnt <= line_end ? H_FIRST : h_cnt + 9'd1;
			end
			if (line_end) begin
				v_cnt <= v_next;
			end
		end
	end

	always_comb begin
		raster.h            = h_cnt;
		raster.v            = {v_cnt[8], v_cnt[7:0] ^ {8{flip}}};
		raster.pix_en       = pix_en_q;
		raster.vblank       = vblank;
		raster.vblank_start = vblank_start_q;
		raster.line_start   = line_start_q;
		raster.frame_end    = frame_end_q;
	end

endmodule

// ==== hdl/sprite_bus_arbiter.sv ====
// External sprite RAM bus owner, pins registered
// Relies on pix_en toggling every clock to predict the next slot
`timescale 1ns/1ps

module sprite_bus_arbiter (
	input  logic                  clk_12M,
	input  logic                  RES_SYNC,
	input  logic                  pix_en,
	input  sprite_pkg::spr_req_t  cpu_req,
	input  sprite_pkg::spr_req_t  copy_req,
	input  logic                  cpu_want,
	input  logic                  copy_want,
	output logic                  cpu_grant,
	output logic                  copy_grant,
	output sprite_pkg::spr_addr_t oa,
	output sprite_pkg::byte_t     od_out,
	output logic                  owr_n,
	output logic                  ooe_n
);

	import sprite_pkg::*;

	logic take_copy;
	logic take_cpu;
	logic take_any;
	spr_req_t sel_req;

	// Next cycle is a pixel slot when pix_en is low now
	assign take_copy = !pix_en && copy_want;
	assign take_cpu  = pix_en && cpu_want;
	assign take_any  = take_copy || take_cpu;
	assign sel_req   = take_copy ? copy_req : cpu_req;

	always_ff @(posedge clk_12M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			cpu_grant  <= 1'b0;
			copy_grant <= 1'b0;
			owr_n      <= 1'b1;
			ooe_n      <= 1'b1;
		end else begin
			cpu_grant  <= take_cpu;
			copy_grant <= take_copy;
			// Idle slot leaves both strobes high
			owr_n <= !(take_any && sel_req.we);
			ooe_n <= !(take_any && !sel_req.we);
		end
	end

	always_ff @(posedge clk_12M) begin
		oa     <= sel_req.addr;
		od_out <= sel_req.wdata;
	end

endmodule

// ==== hdl/sprite_copy.sv ====
// Blanking copy of the 128 sprite entries into the priority-indexed store
// Store has no reset; entries are valid only after a completed copy
`timescale 1ns/1ps

module sprite_copy (
	input  logic                 clk_12M,
	input  logic                 RES_SYNC,
	input  sprite_pkg::raster_t  raster,
	input  logic                 copy_en,
	input  logic                 grant,
	input  sprite_pkg::byte_t    od_in,
	output sprite_pkg::spr_req_t req,
	output logic                 want,
	output logic                 busy,
	input  sprite_pkg::prio_t    attr_index,
	output sprite_pkg::attr_t    attr
);

	import sprite_pkg::*;

	copy_state_t state;
	logic [$clog2(SPR_COUNT)-1:0] spr_num;
	logic [$clog2(SPR_BYTES)-1:0] byte_num;
	logic [$clog2(SPR_BYTES)-1:0] byte_sel;
	prio_t prio_q;
	attr_t attr_mem [SPR_COUNT];

	always_ff @(posedge clk_12M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			state    <= COPY_IDLE;
			spr_num  <= '0;
			byte_num <= '0;
		end else begin
			case (state)
				COPY_IDLE: begin
					if (raster.vblank_start && copy_en) begin
						state    <= COPY_HEAD;
						spr_num  <= '0;
						byte_num <= '0;
					end
				end
				COPY_HEAD: begin
					if (grant) begin
						// Bit 7 is the active flag
						if (od_in[7]) begin
							state    <= COPY_BODY;
							byte_num <= byte_num + 1'b1;
						end else if (&spr_num) begin
							state <= COPY_DONE;
						end else begin
							spr_num <= spr_num + 1'b1;
						end
					end
				end
				COPY_BODY: begin
					if (grant) begin
						byte_num <= byte_num + 1'b1;
						if (&byte_num) begin
							if (&spr_num) begin
								state <= COPY_DONE;
							end else begin
								state   <= COPY_HEAD;
								spr_num <= spr_num + 1'b1;
							end
						end
					end
				end
				// Wait out the rest of blanking
				COPY_DONE: begin
					if (!raster.vblank) begin
						state <= COPY_IDLE;
					end
				end
				default: state <= COPY_IDLE;
			endcase
		end
	end

	assign byte_sel = byte_num - 1'b1;

	always_ff @(posedge clk_12M) begin
		if (state == COPY_HEAD && grant) begin
			prio_q <= od_in[6:0];
		end
		// Later sprite with the same priority overwrites
		if (state == COPY_BODY && grant) begin
			attr_mem[prio_q][{byte_sel, 3'b000} +: 8] <= od_in;
		end
	end

	assign want = (state == COPY_HEAD) || (state == COPY_BODY);
	assign busy = want;

	always_comb begin
		req.addr  = {spr_num, byte_num};
		req.wdata = '0;
		req.we    = 1'b0;
	end

	// Renderer read port
	assign attr = attr_mem[attr_index];

endmodule

// ==== hdl/sprite_ctrl_top.sv ====
// Sprite controller system side, no line rendering
// Sprite RAM read data must return combinationally on od_in
`timescale 1ns/1ps

module sprite_ctrl_top (
	input  logic                  clk_12M,
	input  logic                  RES_SYNC,
	input  sprite_pkg::cpu_bus_t  cpu,
	output sprite_pkg::byte_t     db_out,
	output sprite_pkg::spr_addr_t oa,
	output sprite_pkg::byte_t     od_out,
	output logic                  owr_n,
	output logic                  ooe_n,
	input  sprite_pkg::byte_t     od_in,
	output sprite_pkg::rom_addr_t rom_addr,
	output sprite_pkg::rom_bank_t rom_bank,
	output logic                  irq_n,
	output logic                  firq_n,
	output logic                  nmi_n,
	output logic                  rst,
	output sprite_pkg::raster_t   raster,
	input  sprite_pkg::prio_t     attr_index,
	output sprite_pkg::attr_t     attr
);

	import sprite_pkg::*;

	ctrl_t ctrl;
	spr_req_t cpu_req;
	spr_req_t copy_req;
	logic cpu_want;
	logic copy_want;
	logic cpu_grant;
	logic copy_grant;
	logic copy_busy;

	raster_timer u_raster (
		.clk_12M (clk_12M),
		.RES_SYNC(RES_SYNC),
		.flip    (ctrl.flip),
		.raster  (raster)
	);

	cpu_regs u_regs (
		.clk_12M  (clk_12M),
		.RES_SYNC (RES_SYNC),
		.cpu      (cpu),
		.raster   (raster),
		.copy_busy(copy_busy),
		.spr_grant(cpu_grant),
		.od_in    (od_in),
		.db_out   (db_out),
		.ctrl     (ctrl),
		.spr_req  (cpu_req),
		.spr_want (cpu_want),
		.rom_addr (rom_addr),
		.rom_bank (rom_bank),
		.irq_n    (irq_n),
		.firq_n   (firq_n),
		.nmi_n    (nmi_n),
		.rst      (rst)
	);

	sprite_bus_arbiter u_arb (
		.clk_12M   (clk_12M),
		.RES_SYNC  (RES_SYNC),
		.pix_en    (raster.pix_en),
		.cpu_req   (cpu_req),
		.copy_req  (copy_req),
		.cpu_want  (cpu_want),
		.copy_want (copy_want),
		.cpu_grant (cpu_grant),
		.copy_grant(copy_grant),
		.oa        (oa),
		.od_out    (od_out),
		.owr_n     (owr_n),
		.ooe_n     (ooe_n)
	);

	sprite_copy u_copy (
		.clk_12M   (clk_12M),
		.RES_SYNC  (RES_SYNC),
		.raster    (raster),
		.copy_en   (ctrl.copy_en),
		.grant     (copy_grant),
		.od_in     (od_in),
		.req       (copy_req),
		.want      (copy_want),
		.busy      (copy_busy),
		.attr_index(attr_index),
		.attr      (attr)
	);

endmodule

// ==== hdl/sprite_pkg.sv ====
// Shared types and constants for the sprite controller system side
// Raster limits assume a 384 x 264 frame with a pixel enable every second clock

package sprite_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [9:0]  spr_addr_t;
	typedef logic [10:0] cpu_addr_t;
	typedef logic [8:0]  pix_t;
	typedef logic [6:0]  prio_t;
	// Sprite bytes 1 to 7, byte 1 in bits 7:0
	typedef logic [55:0] attr_t;
	typedef logic [17:0] rom_addr_t;
	typedef logic [7:0]  rom_bank_t;

	typedef enum logic [1:0] {
		COPY_IDLE,
		COPY_HEAD,
		COPY_BODY,
		COPY_DONE
	} copy_state_t;

	typedef struct packed {
		cpu_addr_t ab;
		logic      cs;
		logic      rd;
		logic      wr;
		byte_t     din;
	} cpu_bus_t;

	typedef struct packed {
		pix_t h;
		pix_t v;
		logic pix_en;
		logic vblank;
		logic vblank_start;
		logic line_start;
		logic frame_end;
	} raster_t;

	// Register 0 bits: 0 irq, 1 firq, 2 nmi, 3 flip, 4 copy, 5 rom read
	typedef struct packed {
		logic rom_read;
		logic irq_en;
		logic firq_en;
		logic nmi_en;
		logic flip;
		logic copy_en;
	} ctrl_t;

	typedef struct packed {
		spr_addr_t addr;
		byte_t     wdata;
		logic      we;
	} spr_req_t;

	localparam pix_t H_FIRST = 9'h020;
	localparam pix_t H_LAST  = 9'h19F;
	localparam pix_t V_FIRST = 9'h0F8;
	localparam pix_t V_LAST  = 9'h1FF;
	localparam pix_t VBL_ON  = 9'h1F0;
	localparam pix_t VBL_OFF = 9'h110;

	localparam int SPR_COUNT = 128;
	localparam int SPR_BYTES = 8;

	localparam logic [2:0] REG_CTRL    = 3'd0;
	localparam logic [2:0] REG_BANK_LO = 3'd2;
	localparam logic [2:0] REG_BANK_HI = 3'd3;
	localparam logic [2:0] REG_BANK_X  = 3'd4;

	localparam int RST_FRAMES = 8;

endpackage

// ==== sources.f ====
hdl/sprite_pkg.sv
hdl/raster_timer.sv
hdl/cpu_regs.sv
hdl/sprite_bus_arbiter.sv
hdl/sprite_copy.sv
hdl/sprite_ctrl_top.sv
bench/sprite_ctrl_assert.sv
bench/tb_sprite_ctrl.sv
